// ==== Bender.yml ====
package:
  name: dcache

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/dcache_pkg.sv
      - design/l2_pkg.sv
      - design/dcache_tag_array.sv
      - design/dcache_data_array.sv
      - design/dcache_miss_unit.sv
      - design/dcache_pipeline.sv
      - design/dcache.sv
  - target: test
    include_dirs:
      - design
    files:
      - verification/l2_memory_model.sv
      - verification/dcache_tb.sv

// ==== compile.f ====
+incdir+design
design/dcache_pkg.sv
design/l2_pkg.sv
design/dcache_tag_array.sv
design/dcache_data_array.sv
design/dcache_miss_unit.sv
design/dcache_pipeline.sv
design/dcache.sv
verification/l2_memory_model.sv
verification/dcache_tb.sv

// ==== design/dcache.sv ====
// data cache top, 32 KB 4-way write-through, joining pipeline, arrays and miss unit
`default_nettype none

module dcache (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       req_valid,
  input  wire dcache_pkg::lsq_req_t lsq_req,
  output logic                      lsq_ready,
  output logic                      resp_valid,
  output dcache_pkg::lsq_resp_t     lsq_resp,
  output logic                      l2_req_valid,
  output l2_pkg::l2_req_t           l2_req,
  input  wire                       l2_ready,
  input  wire                       l2_resp_valid,
  input  wire l2_pkg::beat_data_t   l2_resp_data
);
  import dcache_pkg::*;
  import l2_pkg::*;

  // lookup
  logic [31:0] lookup_addr;
  logic        hit;
  way_onehot_t hit_way;
  way_onehot_t victim_way;
  logic        touch;

  // data array
  data_index_t rd_index;
  beat_data_t  rd_data;
  data_wr_t    st_wr;
  data_wr_t    fill_wr;

  // miss handling
  logic        alloc;
  line_addr_t  alloc_line;
  way_onehot_t alloc_way;
  logic        busy;
  logic        fill_done;
  line_addr_t  fill_line;
  logic        invalidate;
  logic        line_req_valid;
  logic        install;
  way_onehot_t install_way;

  dcache_pipeline pipeline_i (.*);

  dcache_tag_array tag_array_i (
    .install_line (fill_line),
    .*
  );

  dcache_data_array data_array_i (.*);

  dcache_miss_unit miss_unit_i (.*);

endmodule

`default_nettype wire

// ==== design/dcache_data_array.sv ====
// dcache data array of 4096 x 64-bit entries with a byte-masked write and a registered read
`default_nettype none
`include "dcache_settings.svh"

module dcache_data_array (
  input  wire                         clk,
  input  wire dcache_pkg::data_index_t rd_index,
  output logic [8*`DC_BEAT_BYTES-1:0] rd_data,
  input  wire dcache_pkg::data_wr_t   st_wr,
  input  wire dcache_pkg::data_wr_t   fill_wr
);
  import dcache_pkg::*;

  localparam int DEPTH = `DC_SETS * `DC_WAYS * `DC_LINE_BYTES / `DC_BEAT_BYTES;

  logic [8*`DC_BEAT_BYTES-1:0] mem [DEPTH];
  data_wr_t                    wr;

  // store hits and fill beats share one physical write port
  assign wr = (|st_wr.mask) ? st_wr : fill_wr;

  always_ff @(posedge clk) begin
    for (int b = 0; b < `DC_BEAT_BYTES; b++) begin
      if (wr.mask[b]) begin
        mem[wr.index][8*b +: 8] <= wr.data[8*b +: 8];
      end
    end
    rd_data <= mem[rd_index];
  end

  // stage 0 holds every request while a line is filling
  a_single_writer: assert property (@(posedge clk)
    (|st_wr.mask) |-> !(|fill_wr.mask));

endmodule

`default_nettype wire

// ==== design/dcache_miss_unit.sv ====
// dcache miss unit, a single miss register that fetches one line from L2 as eight beats
`default_nettype none
`include "dcache_settings.svh"

module dcache_miss_unit (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          alloc,
  input  wire l2_pkg::line_addr_t      alloc_line,
  input  wire dcache_pkg::way_onehot_t alloc_way,
  output logic                         busy,
  output logic                         fill_done,
  output l2_pkg::line_addr_t           fill_line,
  output logic                         invalidate,
  output logic                         line_req_valid,
  input  wire                          l2_ready,
  input  wire                          l2_resp_valid,
  input  wire l2_pkg::beat_data_t      l2_resp_data,
  output dcache_pkg::data_wr_t         fill_wr,
  output logic                         install,
  output dcache_pkg::way_onehot_t      install_way
);
  import dcache_pkg::*;
  import l2_pkg::*;

  beat_idx_t beat_cnt;
  logic      beat;

  assign beat      = busy && l2_resp_valid;
  // last beat writes the data array and installs the tag on the same edge
  assign fill_done = beat && (&beat_cnt);
  assign install   = fill_done;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      line_req_valid <= 1'b0;
      invalidate <= 1'b0;
      beat_cnt <= '0;
    end else begin
      // victim goes invalid the cycle after allocation
      invalidate <= alloc;
      if (alloc) begin
        busy <= 1'b1;
        line_req_valid <= 1'b1;
        beat_cnt <= '0;
      end else begin
        if (line_req_valid && l2_ready) begin
          line_req_valid <= 1'b0;
        end
        if (beat) begin
          beat_cnt <= beat_cnt + 1'b1;
        end
        if (fill_done) begin
          busy <= 1'b0;
        end
      end
    end
  end

  // line and way stay put for the whole fill
  always_ff @(posedge clk) begin
    if (alloc) begin
      fill_line <= alloc_line;
      install_way <= alloc_way;
    end
  end

  // every beat is a full-width write
  always_comb begin
    fill_wr.index.set  = fill_line[`DC_SET_W-1:0];
    fill_wr.index.way  = way_index(install_way);
    fill_wr.index.beat = beat_cnt;
    fill_wr.mask       = {`DC_BEAT_BYTES{beat}};
    fill_wr.data       = l2_resp_data;
  end

endmodule

`default_nettype wire

// ==== design/dcache_pipeline.sv ====
// dcache pipeline with request, lookup and response stages, store alignment and L2 requests
`default_nettype none

module dcache_pipeline (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          req_valid,
  input  wire dcache_pkg::lsq_req_t    lsq_req,
  output logic                         lsq_ready,
  output logic                         resp_valid,
  output dcache_pkg::lsq_resp_t        lsq_resp,
  output logic                         l2_req_valid,
  output l2_pkg::l2_req_t              l2_req,
  input  wire                          l2_ready,
  output logic [31:0]                  lookup_addr,
  input  wire dcache_pkg::way_onehot_t hit_way,
  input  wire                          hit,
  input  wire dcache_pkg::way_onehot_t victim_way,
  output logic                         touch,
  output dcache_pkg::data_index_t      rd_index,
  input  wire l2_pkg::beat_data_t      rd_data,
  output dcache_pkg::data_wr_t         st_wr,
  output logic                         alloc,
  output l2_pkg::line_addr_t           alloc_line,
  output dcache_pkg::way_onehot_t      alloc_way,
  input  wire                          busy,
  input  wire                          fill_done,
  input  wire l2_pkg::line_addr_t      fill_line,
  input  wire                          line_req_valid
);
  import dcache_pkg::*;
  import l2_pkg::*;

  // stage 0, request and tag lookup
  logic        s0_valid;
  lsq_req_t    s0_req;
  logic        s0_load;
  logic        s0_store;
  logic        s0_stall;
  logic        st_issue;
  data_index_t s0_index;
  logic [3:0]  st_mask;
  logic [31:0] st_data;

  // stage 1, data array read
  logic        s1_valid;
  mem_op_t     s1_op;
  lsqid_t      s1_lsqid;
  logic [2:0]  s1_offset;

  // stage 2, response formatting
  logic        s2_valid;
  mem_op_t     s2_op;
  lsqid_t      s2_lsqid;
  logic [2:0]  s2_offset;
  beat_data_t  s2_data;
  logic [31:0] s2_word;
  logic [31:0] s2_shifted;

  assign s0_load  = s0_valid && !s0_req.op[0];
  assign s0_store = s0_valid && s0_req.op[0];

  // loads wait for their line, stores wait for L2 to take the write
  assign s0_stall = s0_valid && (busy || (s0_load && !hit) || (s0_store && !l2_ready));
  assign lsq_ready = !s0_stall;
  assign st_issue  = s0_store && !busy;

  assign lookup_addr = s0_req.addr;
  assign touch       = s0_valid && hit && !s0_stall;

  assign alloc      = s0_load && !hit && !busy;
  assign alloc_line = s0_req.addr[31:OFF_W];
  assign alloc_way  = victim_way;

  assign s0_index.set  = addr_set(s0_req.addr);
  assign s0_index.way  = way_index(hit_way);
  assign s0_index.beat = s0_req.addr[OFF_W-1 -: BEAT_W];
  assign rd_index      = s0_index;

  // replicate store data across the word, mask picks the bytes
  always_comb begin
    case (s0_req.op[2:1])
      2'b00: begin
        st_mask = 4'b0001 << s0_req.addr[1:0];
        st_data = {4{s0_req.wdata[7:0]}};
      end
      2'b01: begin
        st_mask = 4'b0011 << {s0_req.addr[1], 1'b0};
        st_data = {2{s0_req.wdata[15:0]}};
      end
      default: begin
        st_mask = 4'b1111;
        st_data = s0_req.wdata;
      end
    endcase
  end

  // a store hit updates the array in the same cycle L2 takes it
  always_comb begin
    st_wr.index = s0_index;
    st_wr.data  = {2{st_data}};
    st_wr.mask  = '0;
    if (st_issue && hit && l2_ready) begin
      st_wr.mask = s0_req.addr[2] ? {st_mask, 4'b0000} : {4'b0000, st_mask};
    end
  end

  // line read and store-through never overlap
  assign l2_req_valid = line_req_valid || st_issue;

  always_comb begin
    if (line_req_valid) begin
      l2_req.addr  = {fill_line, {(OFF_W-2){1'b0}}};
      l2_req.wen   = 1'b0;
      l2_req.mask  = '0;
      l2_req.wdata = '0;
    end else begin
      l2_req.addr  = s0_req.addr[31:2];
      l2_req.wen   = 1'b1;
      l2_req.mask  = st_mask;
      l2_req.wdata = st_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s0_valid <= 1'b0;
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      if (!s0_stall) begin
        s0_valid <= req_valid;
      end
      s1_valid <= s0_load && !s0_stall;
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid && !s0_stall) begin
      s0_req <= lsq_req;
    end
    s1_op <= s0_req.op;
    s1_lsqid <= s0_req.lsqid;
    s1_offset <= s0_req.addr[2:0];
    s2_op <= s1_op;
    s2_lsqid <= s1_lsqid;
    s2_offset <= s1_offset;
    s2_data <= rd_data;
  end

  assign s2_word    = s2_offset[2] ? s2_data[63:32] : s2_data[31:0];
  assign s2_shifted = s2_word >> {s2_offset[1:0], 3'b000};

  // bit 3 of the op turns sign extension off
  always_comb begin
    lsq_resp.lsqid = s2_lsqid;
    case (s2_op[2:1])
      2'b00:   lsq_resp.rdata = {{24{!s2_op[3] && s2_shifted[7]}}, s2_shifted[7:0]};
      2'b01:   lsq_resp.rdata = {{16{!s2_op[3] && s2_shifted[15]}}, s2_shifted[15:0]};
      default: lsq_resp.rdata = s2_shifted;
    endcase
  end

  assign resp_valid = s2_valid;

  a_hit_onehot: assert property (@(posedge clk) disable iff (rst)
    s0_valid |-> $onehot0(hit_way));

  // miss register must be idle and take the line on the next edge
  a_alloc_idle: assert property (@(posedge clk) disable iff (rst)
    alloc |-> !busy ##1 busy);

  // a fill always completes the line that the held load is waiting on
  a_fill_line: assert property (@(posedge clk) disable iff (rst)
    fill_done |-> s0_load && (alloc_line == fill_line));

endmodule

`default_nettype wire

// ==== design/dcache_pkg.sv ====
// dcache core-side package with the operation encoding, queue structs and array access types
`default_nettype none
`include "dcache_settings.svh"

package dcache_pkg;

  localparam int OFF_W  = $clog2(`DC_LINE_BYTES);
  localparam int WAY_W  = $clog2(`DC_WAYS);
  localparam int BEAT_W = $clog2(`DC_LINE_BYTES / `DC_BEAT_BYTES);

  // bit 0 store, bits 2:1 size, bit 3 unsigned load
  typedef enum logic [3:0] {
    OP_LB  = 4'b0000,
    OP_LH  = 4'b0010,
    OP_LW  = 4'b0100,
    OP_LBU = 4'b1000,
    OP_LHU = 4'b1010,
    OP_SB  = 4'b0001,
    OP_SH  = 4'b0011,
    OP_SW  = 4'b0101
  } mem_op_t;

  typedef logic [`DC_LSQID_W-1:0] lsqid_t;
  typedef logic [`DC_TAG_W-1:0]   tag_t;
  typedef logic [`DC_SET_W-1:0]   set_t;
  typedef logic [`DC_WAYS-1:0]    way_onehot_t;
  typedef logic [WAY_W-1:0]       way_idx_t;

  typedef struct packed {
    mem_op_t     op;
    logic [31:0] addr;
    lsqid_t      lsqid;
    logic [31:0] wdata;
  } lsq_req_t;

  typedef struct packed {
    lsqid_t      lsqid;
    logic [31:0] rdata;
  } lsq_resp_t;

  // one 64-bit entry of the data array
  typedef struct packed {
    set_t              set;
    way_idx_t          way;
    logic [BEAT_W-1:0] beat;
  } data_index_t;

  // a zero mask means no write
  typedef struct packed {
    data_index_t                 index;
    logic [`DC_BEAT_BYTES-1:0]   mask;
    logic [8*`DC_BEAT_BYTES-1:0] data;
  } data_wr_t;

  function automatic set_t addr_set(logic [31:0] addr);
    return addr[OFF_W +: `DC_SET_W];
  endfunction

  function automatic tag_t addr_tag(logic [31:0] addr);
    return addr[31 -: `DC_TAG_W];
  endfunction

  function automatic way_idx_t way_index(way_onehot_t way);
    way_idx_t idx;
    idx = '0;
    for (int w = 0; w < `DC_WAYS; w++) begin
      if (way[w]) begin
        idx = idx | way_idx_t'(w);
      end
    end
    return idx;
  endfunction

endpackage

`default_nettype wire

// ==== design/dcache_settings.svh ====
// dcache settings, cache geometry and address field widths
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// 32 KB, 4 ways, 64-byte lines
`define DC_WAYS       4
`define DC_SETS       128
`define DC_LINE_BYTES 64

// one L2 fill beat
`define DC_BEAT_BYTES 8

// tag is addr[31:13], set is addr[12:6]
`define DC_TAG_W      19
`define DC_SET_W      7

// load/store queue entry id
`define DC_LSQID_W    4

`endif

// ==== design/dcache_tag_array.sv ====
// dcache tag array holding tags, valid bits and tree PLRU state, with hit compare and victim choice
`default_nettype none
`include "dcache_settings.svh"

module dcache_tag_array (
  input  wire                          clk,
  input  wire                          rst,
  input  wire [31:0]                   lookup_addr,
  output logic                         hit,
  output dcache_pkg::way_onehot_t      hit_way,
  output dcache_pkg::way_onehot_t      victim_way,
  input  wire                          touch,
  input  wire                          install,
  input  wire l2_pkg::line_addr_t      install_line,
  input  wire dcache_pkg::way_onehot_t install_way,
  input  wire                          invalidate
);
  import dcache_pkg::*;

  way_onehot_t valid_mem [`DC_SETS];
  logic [2:0]  lru_mem [`DC_SETS];
  tag_t        tag_mem [`DC_SETS][`DC_WAYS];

  set_t        lk_set;
  tag_t        lk_tag;
  way_onehot_t lk_valid;
  logic [2:0]  lk_lru;
  way_onehot_t invalid_ways;
  way_onehot_t lru_way;
  set_t        in_set;
  tag_t        in_tag;
  way_idx_t    in_way;

  // bit 2 picks a half, bit 1 ways 2/3, bit 0 ways 0/1; a set bit means the upper one
  function automatic logic [2:0] lru_touch(logic [2:0] lru, way_idx_t way);
    logic [2:0] nxt;
    nxt = lru;
    nxt[2] = ~way[1];
    if (way[1]) begin
      nxt[1] = ~way[0];
    end else begin
      nxt[0] = ~way[0];
    end
    return nxt;
  endfunction

  assign lk_set   = addr_set(lookup_addr);
  assign lk_tag   = addr_tag(lookup_addr);
  assign lk_valid = valid_mem[lk_set];
  assign lk_lru   = lru_mem[lk_set];

  always_comb begin
    for (int w = 0; w < `DC_WAYS; w++) begin
      hit_way[w] = lk_valid[w] && (tag_mem[lk_set][w] == lk_tag);
    end
  end

  assign hit = |hit_way;

  // walk the tree toward the least recently used way
  always_comb begin
    lru_way = '0;
    if (!lk_lru[2]) begin
      lru_way[{1'b0, lk_lru[0]}] = 1'b1;
    end else begin
      lru_way[{1'b1, lk_lru[1]}] = 1'b1;
    end
  end

  // lowest invalid way wins over the tree
  assign invalid_ways = ~lk_valid;
  assign victim_way   = (|invalid_ways) ? (invalid_ways & (~invalid_ways + 1'b1)) : lru_way;

  assign in_set = install_line[`DC_SET_W-1:0];
  assign in_tag = install_line[`DC_SET_W +: `DC_TAG_W];
  assign in_way = way_index(install_way);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < `DC_SETS; s++) begin
        valid_mem[s] <= '0;
        lru_mem[s] <= '0;
      end
    end else begin
      if (touch) begin
        lru_mem[lk_set] <= lru_touch(lk_lru, way_index(hit_way));
      end
      if (invalidate) begin
        valid_mem[in_set][in_way] <= 1'b0;
      end else if (install) begin
        valid_mem[in_set][in_way] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (install) begin
      tag_mem[in_set][in_way] <= in_tag;
    end
  end

  // the victim was cleared at allocation and nothing may revalidate it before the fill ends
  a_install_on_invalid: assert property (@(posedge clk) disable iff (rst)
    install |-> !valid_mem[in_set][in_way]);

endmodule

`default_nettype wire

// ==== design/l2_pkg.sv ====
// L2 port package with the request struct, line and beat addressing and beat data
`default_nettype none
`include "dcache_settings.svh"

package l2_pkg;

  localparam int LINE_W = `DC_TAG_W + `DC_SET_W;
  localparam int BEATS  = `DC_LINE_BYTES / `DC_BEAT_BYTES;

  // byte address bits 31:6
  typedef logic [LINE_W-1:0] line_addr_t;
  // byte address bits 31:2
  typedef logic [29:0] word_addr_t;
  // beats come back in ascending order from 0
  typedef logic [$clog2(BEATS)-1:0] beat_idx_t;
  typedef logic [8*`DC_BEAT_BYTES-1:0] beat_data_t;

  // with wen low this reads a whole line from a line-aligned address
  typedef struct packed {
    word_addr_t  addr;
    logic        wen;
    logic [3:0]  mask;
    logic [31:0] wdata;
  } l2_req_t;

endpackage

`default_nettype wire

// ==== verification/dcache_tb.sv ====
// dcache testbench with reference memory, PLRU prediction and assertion-based checks
`default_nettype none
`include "dcache_settings.svh"

module dcache_tb;
  import dcache_pkg::*;
  import l2_pkg::*;

  // 85 requests, a miss with L2 stalls takes about 20 cycles, twice that as margin
  localparam int CYCLE_LIMIT = 4000;
  localparam int RING = 32;

  typedef struct packed {
    lsqid_t      lsqid;
    logic [31:0] rdata;
    logic        hit;
    logic [31:0] cyc;
  } exp_resp_t;

  typedef struct packed {
    word_addr_t  addr;
    logic [3:0]  mask;
    logic [31:0] data;
  } exp_store_t;

  logic       clk;
  logic       rst;
  logic       req_valid;
  lsq_req_t   lsq_req;
  logic       lsq_ready;
  logic       resp_valid;
  lsq_resp_t  lsq_resp;
  logic       l2_req_valid;
  l2_req_t    l2_req;
  logic       l2_ready;
  logic       l2_resp_valid;
  beat_data_t l2_resp_data;
  logic       ready_low;
  logic       random_ready;

  logic [31:0] cyc;
  lsqid_t      next_id;
  int          resp_errors;
  int          store_errors;
  int          line_errors;
  int          proto_errors;

  // expected traffic, pushed at acceptance and popped when seen
  exp_resp_t  resp_ring [RING];
  exp_store_t store_ring [RING];
  line_addr_t line_ring [RING];
  int         resp_head;
  int         resp_tail;
  int         store_head;
  int         store_tail;
  int         line_head;
  int         line_tail;

  exp_resp_t  resp_exp;
  exp_store_t store_exp;
  line_addr_t line_exp;
  logic       store_fire;
  logic       line_fire;

  // reference memory and per-set PLRU model
  logic [31:0]     ref_mem [word_addr_t];
  logic [3:0]      m_valid [`DC_SETS];
  logic [2:0]      m_lru [`DC_SETS];
  logic [18:0]     m_tag [`DC_SETS][`DC_WAYS];

  dcache dcache_i (
    .clk           (clk),
    .rst           (rst),
    .req_valid     (req_valid),
    .lsq_req       (lsq_req),
    .lsq_ready     (lsq_ready),
    .resp_valid    (resp_valid),
    .lsq_resp      (lsq_resp),
    .l2_req_valid  (l2_req_valid),
    .l2_req        (l2_req),
    .l2_ready      (l2_ready),
    .l2_resp_valid (l2_resp_valid),
    .l2_resp_data  (l2_resp_data)
  );

  l2_memory_model l2_i (
    .clk           (clk),
    .rst           (rst),
    .ready_low     (ready_low),
    .l2_req_valid  (l2_req_valid),
    .l2_req        (l2_req),
    .l2_ready      (l2_ready),
    .l2_resp_valid (l2_resp_valid),
    .l2_resp_data  (l2_resp_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  function automatic logic [31:0] ref_word(word_addr_t a);
    logic [31:0] w;
    w = {2'b00, a};
    if (ref_mem.exists(a)) begin
      return ref_mem[a];
    end
    return {~w[31:16], w[15:0]};
  endfunction

  function automatic logic [31:0] lane_bits(logic [3:0] mask);
    return {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
  endfunction

  function automatic logic [31:0] load_value(mem_op_t op, logic [31:0] addr);
    logic [31:0] s;
    s = ref_word(addr[31:2]) >> (8 * addr[1:0]);
    case (op)
      OP_LB:   return {{24{s[7]}}, s[7:0]};
      OP_LBU:  return {24'h0, s[7:0]};
      OP_LH:   return {{16{s[15]}}, s[15:0]};
      OP_LHU:  return {16'h0, s[15:0]};
      default: return s;
    endcase
  endfunction

  // lowest invalid way, else follow the tree
  function automatic int plru_victim(logic [3:0] valid, logic [2:0] lru);
    for (int w = 0; w < 4; w++) begin
      if (!valid[w]) begin
        return w;
      end
    end
    return lru[2] ? 2 + lru[1] : lru[0];
  endfunction

  // point every tree bit on the path away from the used way
  function automatic logic [2:0] plru_touch(logic [2:0] lru, int way);
    logic [2:0] n;
    n = lru;
    n[2] = (way < 2);
    if (way >= 2) begin
      n[1] = (way == 2);
    end else begin
      n[0] = (way == 0);
    end
    return n;
  endfunction

  task automatic predict_request(lsq_req_t r);
    int          set;
    int          way;
    logic        hit;
    logic [3:0]  mask;
    logic [31:0] data;
    logic [31:0] word;
    exp_resp_t   e;
    exp_store_t  s;
    set = r.addr[12:6];
    way = 0;
    hit = 1'b0;
    for (int w = 0; w < 4; w++) begin
      if (m_valid[set][w] && m_tag[set][w] == r.addr[31:13]) begin
        hit = 1'b1;
        way = w;
      end
    end
    if (r.op[0]) begin
      case (r.op[2:1])
        2'b00:   mask = 4'b0001 << r.addr[1:0];
        2'b01:   mask = 4'b0011 << r.addr[1:0];
        default: mask = 4'b1111;
      endcase
      data = r.wdata << (8 * r.addr[1:0]);
      word = ref_word(r.addr[31:2]);
      ref_mem[r.addr[31:2]] = (word & ~lane_bits(mask)) | (data & lane_bits(mask));
      s = '{addr: r.addr[31:2], mask: mask, data: data};
      store_ring[store_tail % RING] <= s;
      store_tail <= store_tail + 1;
      if (hit) begin
        m_lru[set] = plru_touch(m_lru[set], way);
      end
    end else begin
      if (!hit) begin
        way = plru_victim(m_valid[set], m_lru[set]);
        m_valid[set][way] = 1'b1;
        m_tag[set][way] = r.addr[31:13];
        line_ring[line_tail % RING] <= r.addr[31:6];
        line_tail <= line_tail + 1;
      end
      m_lru[set] = plru_touch(m_lru[set], way);
      e = '{lsqid: r.lsqid, rdata: load_value(r.op, r.addr), hit: hit, cyc: cyc};
      resp_ring[resp_tail % RING] <= e;
      resp_tail <= resp_tail + 1;
    end
  endtask

  assign resp_exp   = resp_ring[resp_head % RING];
  assign store_exp  = store_ring[store_head % RING];
  assign line_exp   = line_ring[line_head % RING];
  assign store_fire = l2_req_valid && l2_ready && l2_req.wen;
  assign line_fire  = l2_req_valid && l2_ready && !l2_req.wen;

  always @(posedge clk) begin
    if (!rst && req_valid && lsq_ready) begin
      predict_request(lsq_req);
    end
    if (resp_valid && resp_head != resp_tail) begin
      resp_head <= resp_head + 1;
    end
    if (store_fire && store_head != store_tail) begin
      store_head <= store_head + 1;
    end
    if (line_fire && line_head != line_tail) begin
      line_head <= line_head + 1;
    end
  end

  a_resp_expected: assert property (@(posedge clk) disable iff (rst)
    resp_valid |-> resp_head != resp_tail)
    else begin
      resp_errors++;
      $display("response at %0t with no load outstanding", $time);
    end

  a_resp_lsqid: assert property (@(posedge clk) disable iff (rst)
    resp_valid && resp_head != resp_tail |-> lsq_resp.lsqid == resp_exp.lsqid)
    else begin
      resp_errors++;
      $display("CHECK FAILED time=%0t lsq_resp.lsqid expected=%h actual=%h",
               $time, $sampled(resp_exp.lsqid), $sampled(lsq_resp.lsqid));
    end

  a_resp_data: assert property (@(posedge clk) disable iff (rst)
    resp_valid && resp_head != resp_tail |-> lsq_resp.rdata == resp_exp.rdata)
    else begin
      resp_errors++;
      $display("CHECK FAILED time=%0t lsq_resp.rdata expected=%h actual=%h",
               $time, $sampled(resp_exp.rdata), $sampled(lsq_resp.rdata));
    end

  // hit loads answer in the third cycle after the request cycle
  a_hit_latency: assert property (@(posedge clk) disable iff (rst)
    resp_valid && resp_head != resp_tail && resp_exp.hit |-> cyc == resp_exp.cyc + 3)
    else begin
      resp_errors++;
      $display("CHECK FAILED time=%0t resp_valid cycle expected=%0d actual=%0d",
               $time, $sampled(resp_exp.cyc) + 3, $sampled(cyc));
    end

  a_store_expected: assert property (@(posedge clk) disable iff (rst)
    store_fire |-> store_head != store_tail)
    else begin
      store_errors++;
      $display("store-through at %0t that no accepted store explains", $time);
    end

  a_store_addr: assert property (@(posedge clk) disable iff (rst)
    store_fire && store_head != store_tail |-> l2_req.addr == store_exp.addr)
    else begin
      store_errors++;
      $display("CHECK FAILED time=%0t l2_req.addr expected=%h actual=%h",
               $time, $sampled(store_exp.addr), $sampled(l2_req.addr));
    end

  a_store_mask: assert property (@(posedge clk) disable iff (rst)
    store_fire && store_head != store_tail |-> l2_req.mask == store_exp.mask)
    else begin
      store_errors++;
      $display("CHECK FAILED time=%0t l2_req.mask expected=%h actual=%h",
               $time, $sampled(store_exp.mask), $sampled(l2_req.mask));
    end

  a_store_data: assert property (@(posedge clk) disable iff (rst)
    store_fire && store_head != store_tail |->
      (l2_req.wdata & lane_bits(store_exp.mask)) == (store_exp.data & lane_bits(store_exp.mask)))
    else begin
      store_errors++;
      $display("CHECK FAILED time=%0t l2_req.wdata expected=%h actual=%h",
               $time, $sampled(store_exp.data), $sampled(l2_req.wdata));
    end

  a_line_expected: assert property (@(posedge clk) disable iff (rst)
    line_fire |-> line_head != line_tail)
    else begin
      line_errors++;
      $display("line read at %0t where the PLRU model predicts a hit", $time);
    end

  a_line_addr: assert property (@(posedge clk) disable iff (rst)
    line_fire && line_head != line_tail |-> l2_req.addr == {line_exp, 4'b0000})
    else begin
      line_errors++;
      $display("CHECK FAILED time=%0t l2_req.addr expected=%h actual=%h",
               $time, {$sampled(line_exp), 4'b0000}, $sampled(l2_req.addr));
    end

  a_req_hold: assert property (@(posedge clk) disable iff (rst)
    l2_req_valid && !l2_ready |=> l2_req_valid && $stable(l2_req))
    else begin
      proto_errors++;
      $display("L2 request at %0t changed or dropped while l2_ready was low", $time);
    end

  // a missing load, or a store facing a stalled L2, keeps new requests out
  a_ready_low: assert property (@(posedge clk) disable iff (rst)
    line_head != line_tail || (store_head != store_tail && !l2_ready) |-> !lsq_ready)
    else begin
      proto_errors++;
      $display("lsq_ready high at %0t while a miss or a stalled store holds stage 0", $time);
    end

  task automatic send(mem_op_t op, logic [31:0] addr, logic [31:0] wdata);
    lsq_req <= '{op: op, addr: addr, lsqid: next_id, wdata: wdata};
    req_valid <= 1'b1;
    next_id = next_id + 1'b1;
    @(negedge clk);
    while (!lsq_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    req_valid <= 1'b0;
  endtask

  task automatic wait_idle();
    @(negedge clk);
    while (resp_head != resp_tail || store_head != store_tail || line_head != line_tail) begin
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  function automatic logic [31:0] align(mem_op_t op, logic [31:0] addr);
    return addr & ~((32'd1 << op[2:1]) - 1);
  endfunction

  initial begin
    wait (cyc >= CYCLE_LIMIT);
    $display("timeout after %0d cycles with traffic still outstanding", CYCLE_LIMIT);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    mem_op_t     loads [5];
    mem_op_t     all_ops [8];
    mem_op_t     op;
    int          total;
    loads = '{OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
    all_ops = '{OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW};
    void'($urandom(67));
    rst = 1'b1;
    req_valid = 1'b0;
    lsq_req = '0;
    ready_low = 1'b0;
    random_ready = 1'b0;
    cyc = '0;
    next_id = '0;
    resp_errors = 0;
    store_errors = 0;
    line_errors = 0;
    proto_errors = 0;
    resp_head = 0;
    resp_tail = 0;
    store_head = 0;
    store_tail = 0;
    line_head = 0;
    line_tail = 0;
    for (int s = 0; s < `DC_SETS; s++) begin
      m_valid[s] = '0;
      m_lru[s] = '0;
    end
    fork
      forever begin
        @(posedge clk);
        ready_low <= random_ready && ($urandom_range(2) == 0);
      end
    join_none
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    // every load size and sign on fresh lines
    for (int i = 0; i < 15; i++) begin
      op = loads[i % 5];
      send(op, align(op, 32'h0001_0000 + i * 64 + $urandom_range(63)), '0);
    end

    // store then load, first into a filled line, then into a fresh one
    send(OP_SB, 32'h0001_0003, 32'h0000_00a5);
    send(OP_LW, 32'h0001_0000, '0);
    send(OP_SH, 32'h0001_0046, 32'h0000_8123);
    send(OP_LH, 32'h0001_0046, '0);
    send(OP_SW, 32'h0002_0008, 32'hcafe_f00d);
    send(OP_LBU, 32'h0002_000b, '0);
    send(OP_SB, 32'h0002_0081, 32'h0000_0080);
    send(OP_LH, 32'h0002_0080, '0);

    // mixed traffic over four lines with L2 stalling
    random_ready = 1'b1;
    for (int i = 0; i < 48; i++) begin
      op = all_ops[$urandom_range(7)];
      send(op, align(op, 32'h0004_0000 + $urandom_range(255)), $urandom);
    end
    wait_idle();

    // five lines in set 5, then revisits that depend on the PLRU choice
    for (int t = 0; t < 5; t++) begin
      send(OP_LW, {19'(100 + t), 7'd5, 6'd0}, '0);
      if (t == 3) begin
        send(OP_LW, {19'd100, 7'd5, 6'd4}, '0);
      end
    end
    for (int t = 0; t < 5; t++) begin
      send(OP_LW, {19'(100 + t), 7'd5, 6'd8}, '0);
    end
    wait_idle();

    // repeat a just-filled line with L2 always ready
    random_ready = 1'b0;
    wait_idle();
    send(OP_LW, 32'h0008_0040, '0);
    wait_idle();
    send(OP_LHU, 32'h0008_0052, '0);
    send(OP_LB, 32'h0008_007f, '0);
    wait_idle();

    total = resp_errors + store_errors + line_errors + proto_errors;
    $display("errors: response %0d, store %0d, line read %0d, protocol %0d",
             resp_errors, store_errors, line_errors, proto_errors);
    if (total == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/l2_memory_model.sv ====
// behavioral L2 that answers line reads in eight beats and applies masked store-throughs
`default_nettype none

module l2_memory_model (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  ready_low,
  input  wire                  l2_req_valid,
  input  wire l2_pkg::l2_req_t l2_req,
  output logic                 l2_ready,
  output logic                 l2_resp_valid,
  output l2_pkg::beat_data_t   l2_resp_data
);
  import l2_pkg::*;

  logic [31:0] mem [word_addr_t];
  logic        active;
  beat_idx_t   beat;
  line_addr_t  line;

  // untouched word w holds w with its upper half inverted
  function automatic logic [31:0] word_at(word_addr_t a);
    logic [31:0] w;
    w = {2'b00, a};
    if (mem.exists(a)) begin
      return mem[a];
    end
    return {~w[31:16], w[15:0]};
  endfunction

  assign l2_ready = !ready_low;

  always @(posedge clk) begin
    if (rst) begin
      active <= 1'b0;
      beat <= '0;
      l2_resp_valid <= 1'b0;
      l2_resp_data <= '0;
    end else begin
      l2_resp_valid <= 1'b0;
      if (active) begin
        l2_resp_valid <= 1'b1;
        l2_resp_data <= {word_at({line, beat, 1'b1}), word_at({line, beat, 1'b0})};
        beat <= beat + 1'b1;
        if (&beat) begin
          active <= 1'b0;
        end
      end
      if (l2_req_valid && l2_ready) begin
        if (l2_req.wen) begin
          for (int b = 0; b < 4; b++) begin
            if (l2_req.mask[b]) begin
              mem[l2_req.addr] = word_at(l2_req.addr);
              mem[l2_req.addr][8*b +: 8] = l2_req.wdata[8*b +: 8];
            end
          end
        end else begin
          active <= 1'b1;
          beat <= '0;
          line <= l2_req.addr[29:4];
        end
      end
    end
  end

endmodule

`default_nettype wire
